// File: logic/fetch_pkg.sv
// Shared widths, depths and payload types of the instruction fetch frontend.
// Every frontend module and the testbench refer to these by scoped name.

package fetch_pkg;

   // Address and instruction geometry
   localparam int AW         = 32;
   localparam int INSN_W     = 32;
   localparam int P_INSN_LEN = 2;
   localparam int PC_W       = AW - P_INSN_LEN;

   // Two-slot fetch window, two decode outputs
   localparam int P_FETCH_W = 1;
   localparam int FW        = 1 << P_FETCH_W;
   localparam int IW        = 2;
   localparam int CNT_W     = $clog2(IW + 1);

   // Prefetch queue
   localparam int IQ_DEPTH = 8;
   localparam int IQ_PTR_W = $clog2(IQ_DEPTH);

   // Word address of the first fetch
   localparam logic [PC_W-1:0] PC_RST = PC_W'('h100);

   // Conditional branch: opcode in bits 31..26, signed word offset below it
   localparam int BR_OFS_W = 26;
   localparam logic [INSN_W-BR_OFS_W-1:0] BCC_OPCODE = 6'h05;

   // One fetched instruction with its word PC
   typedef struct packed
   {
      logic [INSN_W-1:0] insn;
      logic [PC_W-1:0]   pc;
   } fetch_entry_t;

   // Static prediction result of one fetch slot
   typedef struct packed
   {
      logic            taken;
      logic [PC_W-1:0] tgt;
   } slot_pred_t;

endpackage

// File: logic/fetch_pc_gen.sv
// Next-PC generation and the stage-1 window registers of the fetch frontend.
// Produces the aligned memory address and the final per-slot push mask.
`timescale 1ns/1ps

module fetch_pc_gen
(
   input  logic                                          clk,
   input  logic                                          rst_n,
   input  logic                                          flush,
   input  logic [fetch_pkg::PC_W-1:0]                    flush_tgt,
   input  logic                                          ready,
   input  fetch_pkg::slot_pred_t [fetch_pkg::FW-1:0]     pred,
   output logic [fetch_pkg::AW-1:0]                      imem_addr,
   output logic [fetch_pkg::PC_W-1:0]                    s1_base_pc,
   output logic [fetch_pkg::FW-1:0]                      s1_valid_pre,
   output logic [fetch_pkg::FW-1:0]                      push_mask
);
   logic [fetch_pkg::PC_W-1:0]      pc;
   logic [fetch_pkg::PC_W-1:0]      pc_nxt;
   logic [fetch_pkg::FW-1:0]        s0_aligned;
   logic [fetch_pkg::FW-1:0]        s1_aligned;
   logic                            s1_valid;
   logic                            pred_taken;
   logic [fetch_pkg::PC_W-1:0]      pred_tgt;
   logic [fetch_pkg::P_FETCH_W:0]   push_cnt;

   assign s1_valid_pre = s1_aligned & {fetch_pkg::FW{s1_valid}};

   // Keep slots up to and including the first taken branch
   always_comb
   begin
      pred_taken = 1'b0;
      pred_tgt   = '0;
      push_mask  = '0;
      push_cnt   = '0;
      for (int i = 0; i < fetch_pkg::FW; i++)
      begin
         if (s1_valid_pre[i] && !pred_taken)
         begin
            push_mask[i] = 1'b1;
            push_cnt     = push_cnt + (fetch_pkg::P_FETCH_W+1)'(1);
            if (pred[i].taken)
            begin
               pred_taken = 1'b1;
               pred_tgt   = pred[i].tgt;
            end
         end
      end
   end

   // Next PC, highest priority first
   always_comb
   begin
      if (flush)
         pc_nxt = flush_tgt;
      else if (!ready)
         pc_nxt = pc;
      else if (pred_taken)
         pc_nxt = pred_tgt;
      else
         pc_nxt = pc + fetch_pkg::PC_W'(push_cnt);
   end

   // Slots below the entry offset are not part of the stream
   always_comb
   begin
      for (int i = 0; i < fetch_pkg::FW; i++)
         s0_aligned[i] = pc_nxt[fetch_pkg::P_FETCH_W-1:0] <= fetch_pkg::P_FETCH_W'(i);
   end

   assign imem_addr = {pc_nxt[fetch_pkg::PC_W-1:fetch_pkg::P_FETCH_W],
                       {(fetch_pkg::P_FETCH_W + fetch_pkg::P_INSN_LEN){1'b0}}};

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         pc         <= fetch_pkg::PC_RST;
         s1_valid   <= 1'b0;
         s1_aligned <= '0;
      end
      else
      begin
         pc <= pc_nxt;
         if (ready || flush)
         begin
            s1_valid   <= !flush;
            s1_aligned <= s0_aligned;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (ready || flush)
         s1_base_pc <= {pc_nxt[fetch_pkg::PC_W-1:fetch_pkg::P_FETCH_W],
                        {fetch_pkg::P_FETCH_W{1'b0}}};
   end

endmodule

// File: logic/branch_predecode.sv
// Per-slot predecode lane: restores the slot PC and applies the static rule
// that a backward conditional branch is taken. One instance per fetch slot.
`timescale 1ns/1ps

module branch_predecode
#(
   parameter int LANE = 0
)
(
   input  logic [fetch_pkg::PC_W-1:0]     s1_base_pc,
   input  logic [fetch_pkg::INSN_W-1:0]   insn,
   output fetch_pkg::fetch_entry_t        entry,
   output fetch_pkg::slot_pred_t          pred
);
   logic [fetch_pkg::PC_W-1:0]                         slot_pc;
   logic [fetch_pkg::INSN_W-fetch_pkg::BR_OFS_W-1:0]   opcode;
   logic [fetch_pkg::BR_OFS_W-1:0]                     ofs;
   logic                                               is_bcc;
   logic [fetch_pkg::PC_W-1:0]                         ofs_ext;

   // Window base has its low bits clear, so this is the slot's own PC
   assign slot_pc = s1_base_pc + fetch_pkg::PC_W'(LANE);

   assign opcode = insn[fetch_pkg::INSN_W-1:fetch_pkg::BR_OFS_W];
   assign ofs    = insn[fetch_pkg::BR_OFS_W-1:0];
   assign is_bcc = (opcode == fetch_pkg::BCC_OPCODE);

   // Sign-extend the word offset
   assign ofs_ext = {{(fetch_pkg::PC_W - fetch_pkg::BR_OFS_W){ofs[fetch_pkg::BR_OFS_W-1]}}, ofs};

   assign entry.insn = insn;
   assign entry.pc   = slot_pc;

   // Backward means a loop, so predict taken
   assign pred.taken = is_bcc & ofs[fetch_pkg::BR_OFS_W-1];
   assign pred.tgt   = slot_pc + ofs_ext;

endmodule

// File: logic/fetch_queue.sv
// Prefetch queue between fetch and decode. Packs the pushed slots of one
// window at consecutive positions and shows up to IW entries to decode.
`timescale 1ns/1ps

module fetch_queue
(
   input  logic                                          clk,
   input  logic                                          rst_n,
   input  logic                                          flush,
   input  logic                                          push_en,
   input  logic [fetch_pkg::FW-1:0]                      push_mask,
   input  fetch_pkg::fetch_entry_t [fetch_pkg::FW-1:0]   push_entry,
   input  logic [fetch_pkg::CNT_W-1:0]                   id_pop_cnt,
   output logic                                          ready,
   output logic [fetch_pkg::IW-1:0]                      id_valid,
   output fetch_pkg::fetch_entry_t [fetch_pkg::IW-1:0]   id_entry
);
   fetch_pkg::fetch_entry_t            mem [fetch_pkg::IQ_DEPTH];
   logic [fetch_pkg::IQ_PTR_W-1:0]     rptr;
   logic [fetch_pkg::IQ_PTR_W-1:0]     wptr;
   logic [fetch_pkg::IQ_PTR_W:0]       count;
   logic [fetch_pkg::IQ_PTR_W-1:0]     waddr [fetch_pkg::FW];
   logic [fetch_pkg::IQ_PTR_W:0]       push_cnt;
   logic [fetch_pkg::IQ_PTR_W:0]       push_num;

   // Compact the set slots onto consecutive write addresses
   always_comb
   begin
      push_cnt = '0;
      for (int i = 0; i < fetch_pkg::FW; i++)
      begin
         waddr[i] = wptr + push_cnt[fetch_pkg::IQ_PTR_W-1:0];
         if (push_mask[i])
            push_cnt = push_cnt + (fetch_pkg::IQ_PTR_W+1)'(1);
      end
   end

   assign push_num = push_en ? push_cnt : '0;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rptr  <= '0;
         wptr  <= '0;
         count <= '0;
      end
      else if (flush)
      begin
         rptr  <= '0;
         wptr  <= '0;
         count <= '0;
      end
      else
      begin
         wptr  <= wptr + push_num[fetch_pkg::IQ_PTR_W-1:0];
         rptr  <= rptr + fetch_pkg::IQ_PTR_W'(id_pop_cnt);
         count <= count + push_num - (fetch_pkg::IQ_PTR_W+1)'(id_pop_cnt);
      end
   end

   always_ff @(posedge clk)
   begin
      if (push_en)
      begin
         for (int i = 0; i < fetch_pkg::FW; i++)
         begin
            if (push_mask[i])
               mem[waddr[i]] <= push_entry[i];
         end
      end
   end

   // Room for a whole window
   assign ready = (count <= (fetch_pkg::IQ_PTR_W+1)'(fetch_pkg::IQ_DEPTH - fetch_pkg::FW));

   // Head entries, valid bits contiguous from bit 0
   always_comb
   begin
      for (int k = 0; k < fetch_pkg::IW; k++)
      begin
         id_valid[k] = (count > (fetch_pkg::IQ_PTR_W+1)'(k));
         id_entry[k] = mem[rptr + fetch_pkg::IQ_PTR_W'(k)];
      end
   end

endmodule

// File: logic/fetch_frontend.sv
// Top level of the fetch frontend: PC generator, one predecode lane per slot
// and the prefetch queue feeding decode. Talks to a one-cycle instruction memory.
`timescale 1ns/1ps

module fetch_frontend
(
   input  logic                                                  clk,
   input  logic                                                  rst_n,
   input  logic                                                  flush,
   input  logic [fetch_pkg::PC_W-1:0]                            flush_tgt,
   output logic                                                  imem_en,
   output logic [fetch_pkg::AW-1:0]                              imem_addr,
   input  logic [fetch_pkg::FW-1:0][fetch_pkg::INSN_W-1:0]       imem_rdata,
   output logic [fetch_pkg::IW-1:0]                              id_valid,
   output fetch_pkg::fetch_entry_t [fetch_pkg::IW-1:0]           id_entry,
   input  logic [fetch_pkg::CNT_W-1:0]                           id_pop_cnt
);
   logic                                          ready;
   logic [fetch_pkg::PC_W-1:0]                    s1_base_pc;
   logic [fetch_pkg::FW-1:0]                      push_mask;
   fetch_pkg::fetch_entry_t [fetch_pkg::FW-1:0]   lane_entry;
   fetch_pkg::slot_pred_t [fetch_pkg::FW-1:0]     lane_pred;

   // Memory and pipeline advance together
   assign imem_en = ready;

   fetch_pc_gen u_pc_gen
   (
      .clk           (clk),
      .rst_n         (rst_n),
      .flush         (flush),
      .flush_tgt     (flush_tgt),
      .ready         (ready),
      .pred          (lane_pred),
      .imem_addr     (imem_addr),
      .s1_base_pc    (s1_base_pc),
      // Stage-1 mask reaches the queue through push_mask
      .s1_valid_pre  (),
      .push_mask     (push_mask)
   );

   for (genvar g = 0; g < fetch_pkg::FW; g++)
   begin : g_lane
      branch_predecode #(.LANE(g)) u_predecode
      (
         .s1_base_pc (s1_base_pc),
         .insn       (imem_rdata[g]),
         .entry      (lane_entry[g]),
         .pred       (lane_pred[g])
      );
   end

   fetch_queue u_queue
   (
      .clk           (clk),
      .rst_n         (rst_n),
      .flush         (flush),
      .push_en       (ready),
      .push_mask     (push_mask),
      .push_entry    (lane_entry),
      .id_pop_cnt    (id_pop_cnt),
      .ready         (ready),
      .id_valid      (id_valid),
      .id_entry      (id_entry)
   );

endmodule

// File: verification/fetch_frontend_asserts.sv
// Protocol assertions on the fetch frontend ports.
// Bound into the frontend top level at the end of this file.
`timescale 1ns/1ps

module fetch_frontend_asserts
(
   input logic                             clk,
   input logic                             rst_n,
   input logic                             flush,
   input logic [fetch_pkg::AW-1:0]         imem_addr,
   input logic [fetch_pkg::IW-1:0]         id_valid,
   input logic [fetch_pkg::CNT_W-1:0]      id_pop_cnt
);
   localparam int ALIGN_W = fetch_pkg::P_FETCH_W + fetch_pkg::P_INSN_LEN;

   // Contiguous from bit 0 means all ones below the top valid bit
   valid_contiguous: assert property (@(posedge clk) disable iff (!rst_n)
      ((id_valid + fetch_pkg::IW'(1)) & id_valid) == '0)
   else $error("id_valid is not contiguous from bit 0: %h", id_valid);

   pop_within_valid: assert property (@(posedge clk) disable iff (!rst_n)
      int'(id_pop_cnt) <= $countones(id_valid))
   else $error("id_pop_cnt %h exceeds the valid entries %h", id_pop_cnt, id_valid);

   addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
      imem_addr[ALIGN_W-1:0] == '0)
   else $error("imem_addr %h is not aligned to the fetch window", imem_addr);

   empty_after_flush: assert property (@(posedge clk) disable iff (!rst_n)
      flush |=> id_valid == '0)
   else $error("id_valid is %h in the cycle after a flush", id_valid);

   empty_in_reset: assert property (@(posedge clk)
      !rst_n |-> id_valid == '0)
   else $error("id_valid is %h while reset is asserted", id_valid);

endmodule

bind fetch_frontend fetch_frontend_asserts u_asserts
(
   .clk        (clk),
   .rst_n      (rst_n),
   .flush      (flush),
   .imem_addr  (imem_addr),
   .id_valid   (id_valid),
   .id_pop_cnt (id_pop_cnt)
);

// File: verification/fetch_frontend_tb.sv
// Testbench for the fetch frontend: clock, reset, instruction memory model,
// stimulus and a reference PC stream checked at every decode pop.
`timescale 1ns/1ps

module fetch_frontend_tb;

   localparam int CLK_PERIOD = 4;
   localparam int RST_CYCLES = 3;
   localparam int DRIVE_DLY  = 1;

   // Entries delivered per test and the stall lengths
   localparam int N_SEQ         = 12;
   localparam int N_UNAL        = 6;
   localparam int N_BR          = 30;
   localparam int N_BP          = 40;
   localparam int N_FL          = 8;
   localparam int STALL_CYCLES  = 24;
   localparam int FILL_CYCLES   = 6;
   localparam int CYC_PER_ENTRY = 4;
   localparam int MARGIN_CYCLES = 200;
   localparam int WATCHDOG_NS   = (RST_CYCLES + STALL_CYCLES + FILL_CYCLES + MARGIN_CYCLES
                                   + (N_SEQ + N_UNAL + N_BR + N_BP + N_FL) * CYC_PER_ENTRY)
                                  * CLK_PERIOD;

   // Flush targets, all word addresses
   localparam logic [fetch_pkg::PC_W-1:0] UNAL_TGT = fetch_pkg::PC_W'('h141);
   localparam logic [fetch_pkg::PC_W-1:0] BR_TGT   = fetch_pkg::PC_W'('h11B);
   localparam logic [fetch_pkg::PC_W-1:0] FL_TGT   = fetch_pkg::PC_W'('h160);

   logic                                                  clk;
   logic                                                  rst_n;
   logic                                                  flush;
   logic [fetch_pkg::PC_W-1:0]                            flush_tgt;
   logic                                                  imem_en;
   logic [fetch_pkg::AW-1:0]                              imem_addr;
   logic [fetch_pkg::FW-1:0][fetch_pkg::INSN_W-1:0]       imem_rdata = '0;
   logic [fetch_pkg::IW-1:0]                              id_valid;
   fetch_pkg::fetch_entry_t [fetch_pkg::IW-1:0]           id_entry;
   logic [fetch_pkg::CNT_W-1:0]                           id_pop_cnt;

   int                           seed;
   int                           errors;
   int                           checks;
   int                           tests;
   int                           delivered;
   logic [fetch_pkg::PC_W-1:0]   exp_pc;

   fetch_frontend DUT
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .flush      (flush),
      .flush_tgt  (flush_tgt),
      .imem_en    (imem_en),
      .imem_addr  (imem_addr),
      .imem_rdata (imem_rdata),
      .id_valid   (id_valid),
      .id_entry   (id_entry),
      .id_pop_cnt (id_pop_cnt)
   );

   // Program: backward loop branch at a mod 32 == 13, forward branch at 29
   function automatic logic [fetch_pkg::INSN_W-1:0] prog_word
      (input logic [fetch_pkg::PC_W-1:0] a);
      logic [fetch_pkg::INSN_W-1:0] w;
      if (a % 32 == 29)
         w = {fetch_pkg::BCC_OPCODE, fetch_pkg::BR_OFS_W'(3)};
      else if (a % 16 == 13)
         w = {fetch_pkg::BCC_OPCODE, fetch_pkg::BR_OFS_W'(-6)};
      else
         w = {6'h10, a[25:0] ^ {a[29:26], 22'h2AAAAA}};
      return w;
   endfunction

   // Only a backward branch leaves the straight line
   function automatic logic [fetch_pkg::PC_W-1:0] next_pc(input logic [fetch_pkg::PC_W-1:0] a);
      if (a % 32 == 13)
         return a - fetch_pkg::PC_W'(6);
      return a + fetch_pkg::PC_W'(1);
   endfunction

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // One-cycle synchronous instruction memory
   always @(posedge clk)
   begin
      if (imem_en)
      begin
         for (int i = 0; i < fetch_pkg::FW; i++)
            imem_rdata[i] <= prog_word(imem_addr[fetch_pkg::AW-1:fetch_pkg::P_INSN_LEN]
                                       + fetch_pkg::PC_W'(i));
      end
   end

   task automatic check_entry(input int k);
      checks++;
      assert (id_entry[k].pc == exp_pc)
      else
      begin
         $display("FAIL id_entry[%0d].pc: got %h, expected %h", k, id_entry[k].pc, exp_pc);
         errors++;
      end
      assert (id_entry[k].insn == prog_word(exp_pc))
      else
      begin
         $display("FAIL id_entry[%0d].insn: got %h, expected %h",
                  k, id_entry[k].insn, prog_word(exp_pc));
         errors++;
      end
      exp_pc = next_pc(exp_pc);
      delivered++;
   endtask

   // Pops a random number of entries, at most max_pop and never beyond id_valid
   task automatic pop_cycle(input int max_pop);
      int avail;
      int lim;
      int n;
      @(posedge clk);
      #DRIVE_DLY;
      flush = 1'b0;
      avail = $countones(id_valid);
      lim   = (max_pop < avail) ? max_pop : avail;
      n     = $unsigned($random(seed)) % (lim + 1);
      for (int k = 0; k < n; k++)
         check_entry(k);
      id_pop_cnt = fetch_pkg::CNT_W'(n);
   endtask

   task automatic flush_to(input logic [fetch_pkg::PC_W-1:0] tgt);
      @(posedge clk);
      #DRIVE_DLY;
      flush      = 1'b1;
      flush_tgt  = tgt;
      id_pop_cnt = '0;
      @(posedge clk);
      #DRIVE_DLY;
      flush = 1'b0;
      checks++;
      assert (id_valid == '0)
      else
      begin
         $display("FAIL id_valid after flush: got %h, expected 0", id_valid);
         errors++;
      end
      exp_pc = tgt;
   endtask

   task automatic deliver(input int n_entries, input int max_pop);
      int goal;
      goal = delivered + n_entries;
      while (delivered < goal)
         pop_cycle(max_pop);
   endtask

   task automatic report_test(input string name, input int err_before, input int n_before);
      tests++;
      $display("test %0d %s: %0d entries, %0d errors",
               tests, name, delivered - n_before, errors - err_before);
   endtask

   initial
   begin
      int err0;
      int n0;
      seed       = 32'h8894;
      errors     = 0;
      checks     = 0;
      tests      = 0;
      delivered  = 0;
      rst_n      = 1'b0;
      flush      = 1'b0;
      flush_tgt  = '0;
      id_pop_cnt = '0;
      exp_pc     = fetch_pkg::PC_RST;
      repeat (RST_CYCLES) @(posedge clk);
      #DRIVE_DLY;
      rst_n = 1'b1;

      err0 = errors;
      n0   = delivered;
      deliver(N_SEQ, 2);
      report_test("sequential fetch from reset", err0, n0);

      // Odd target, so the even slot of its window must not appear
      err0 = errors;
      n0   = delivered;
      flush_to(UNAL_TGT);
      deliver(N_UNAL, 2);
      report_test("unaligned entry", err0, n0);

      // Forward branch at 0x11D, then the loop back from 0x12D
      err0 = errors;
      n0   = delivered;
      flush_to(BR_TGT);
      deliver(N_BR, 2);
      report_test("predicted branch", err0, n0);

      err0 = errors;
      n0   = delivered;
      repeat (STALL_CYCLES) pop_cycle(0);
      checks++;
      assert (id_valid == '1 && !imem_en)
      else
      begin
         $display("The queue did not fill and stall fetch while decode popped nothing");
         errors++;
      end
      deliver(N_BP, 2);
      report_test("back-pressure", err0, n0);

      // Flush with entries still queued
      err0 = errors;
      n0   = delivered;
      repeat (FILL_CYCLES) pop_cycle(0);
      flush_to(FL_TGT);
      deliver(N_FL, 2);
      report_test("flush", err0, n0);

      $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
      $display("Done: errors found");
      $finish;
   end

endmodule

// File: fetch_frontend.f
logic/fetch_pkg.sv
logic/fetch_pc_gen.sv
logic/branch_predecode.sv
logic/fetch_queue.sv
logic/fetch_frontend.sv
verification/fetch_frontend_asserts.sv
verification/fetch_frontend_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert --top-module fetch_frontend_tb \
		-f fetch_frontend.f -Mdir obj_dir
	./obj_dir/Vfetch_frontend_tb > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
